// ==== bfp_sample_pkg.sv ====
/*
 * Sample-side types for the block-floating-point normalizer.
 * Complex sample, frame beat with markers, and the frame exponent.
 */

package bfp_sample_pkg;

    // --------------------
    // Widths
    // --------------------

    // Width of each I and Q part
    localparam int SAMPLE_W = 16;

    // Wide enough to hold SAMPLE_W-1, the all-zero exponent
    localparam int EXP_W = $clog2(SAMPLE_W);

    // --------------------
    // Types
    // --------------------

    // Signed complex sample
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } cplx_t;

    // One frame beat, sop and eop mark the frame edges
    typedef struct packed {
        cplx_t data;
        logic  sop;
        logic  eop;
    } beat_t;

    // Left shift applied to a whole frame
    typedef logic [EXP_W-1:0] exp_t;

endpackage

// ==== bfp_flow_pkg.sv ====
/*
 * Flow-control definitions shared by the ingress and the buffers.
 * Buffer depths, credit counter sizing and the exponent buffer item.
 */

package bfp_flow_pkg;

    // Longest frame, sample buffer must hold one whole frame
    localparam int FRAME_MAX = 64;

    // Frames whose exponent may wait in the exponent buffer
    localparam int EXP_DEPTH = 4;

    // Counter width for values 0..depth inclusive
    function automatic int cnt_w(int depth);
        return $clog2(depth + 1);
    endfunction

    // Exponent buffer item, one per frame
    typedef struct packed {
        bfp_sample_pkg::exp_t exp;
    } exp_rec_t;

endpackage

// ==== bfp_peak_scan.sv ====
/*
 * Per-frame peak scan. ORs the one's-complement magnitudes of all I/Q
 * values and turns the final mask into a leading-zero exponent.
 * Exponent is valid for one cycle, one cycle after the eop magnitude.
 */

module bfp_peak_scan
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_vld,
    input  bfp_sample_pkg::beat_t i_beat,
    output logic                  o_exp_vld,
    output bfp_sample_pkg::exp_t  o_exp
);

    localparam int W = bfp_sample_pkg::SAMPLE_W;

    // Registered magnitude of the current beat, zero when idle
    logic [W-1:0] mag_r;
    logic         mag_eop;
    // Running OR over the frame so far
    logic [W-1:0] mask;
    logic [W-1:0] mask_final;

    // Leading zeros below the sign bit, W-1 when nothing is set
    function automatic bfp_sample_pkg::exp_t lzc(logic [W-2:0] m);
        bfp_sample_pkg::exp_t n;
        logic                 hit;
        n   = '0;
        hit = 1'b0;
        for (int i = W - 2; i >= 0; i--)
        begin
            if (m[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 1'b1;
        end
        return n;
    endfunction

    // --------------------
    // Magnitude stage
    // --------------------

    // One's complement for negatives, sign bit always ends up clear
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mag_r   <= '0;
            mag_eop <= 1'b0;
        end
        else if (i_vld)
        begin
            mag_r <= (i_beat.data.re[W-1] ? ~i_beat.data.re : i_beat.data.re)
                   | (i_beat.data.im[W-1] ? ~i_beat.data.im : i_beat.data.im);
            mag_eop <= i_beat.eop;
        end
        else
        begin
            mag_r   <= '0;
            mag_eop <= 1'b0;
        end
    end

    // --------------------
    // Mask and exponent
    // --------------------

    assign mask_final = mask | mag_r;

    // Mask clears on the same edge that captures the exponent
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mask      <= '0;
            o_exp_vld <= 1'b0;
        end
        else
        begin
            mask      <= mag_eop ? '0 : mask_final;
            o_exp_vld <= mag_eop;
        end
    end

    // Exponent payload, qualified by o_exp_vld
    always_ff @(posedge clk)
    begin
        if (mag_eop)
            o_exp <= lzc(mask_final[W-2:0]);
    end

endmodule

// ==== bfp_credit_fifo.sv ====
/*
 * Credit-flow FIFO for any payload type. No full flag; the sender
 * holds DEPTH credits and gets one back through o_credit per pop.
 * Head entry is shown on o_vld/o_data and i_pop removes it.
 */

module bfp_credit_fifo
#(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_push,
    input  T     i_data,
    output logic o_vld,
    output T     o_data,
    input  logic i_pop,
    output logic o_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = bfp_flow_pkg::cnt_w(DEPTH);

    // Entry storage
    T             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop_ok;

    // Pop only counts against a real entry
    assign pop_ok = i_pop && o_vld;

    assign o_vld  = (count != '0);
    assign o_data = mem[rd_ptr];

    // --------------------
    // Storage write
    // --------------------

    always_ff @(posedge clk)
    begin
        if (i_push)
            mem[wr_ptr] <= i_data;
    end

    // --------------------
    // Pointers and count
    // --------------------

    // Explicit wrap keeps non-power-of-two depths legal
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (i_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({i_push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit returned for each popped entry on the next cycle
    always_ff @(posedge clk)
    begin
        if (rst)
            o_credit <= 1'b0;
        else
            o_credit <= pop_ok;
    end

endmodule

// ==== bfp_ingress.sv ====
/*
 * Producer side of the normalizer. Accepts valid/ready beats while it
 * holds credits, pushes them into the sample buffer and the peak scan,
 * and pushes each frame exponent into the exponent buffer.
 */

module bfp_ingress
#(
    parameter int SAMPLE_DEPTH = 64,
    parameter int EXP_DEPTH    = 4
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_in_vld,
    input  bfp_sample_pkg::beat_t    i_in_beat,
    output logic                     o_in_rdy,
    output logic                     o_smp_push,
    output bfp_sample_pkg::beat_t    o_smp_beat,
    input  logic                     i_smp_credit,
    output logic                     o_exp_push,
    output bfp_flow_pkg::exp_rec_t   o_exp_rec,
    input  logic                     i_exp_credit
);

    localparam int SMP_CW = bfp_flow_pkg::cnt_w(SAMPLE_DEPTH);
    localparam int EXP_CW = bfp_flow_pkg::cnt_w(EXP_DEPTH);

    // Credits held for each buffer
    logic [SMP_CW-1:0]    smp_cred;
    logic [EXP_CW-1:0]    exp_cred;
    logic                 accept;
    // Credit spends this cycle
    logic                 smp_spend;
    logic                 exp_spend;
    logic                 scan_vld;
    bfp_sample_pkg::exp_t scan_exp;

    // --------------------
    // Ready and accept
    // --------------------

    // An eop beat also needs room for its exponent
    assign o_in_rdy = (smp_cred != '0) && (!i_in_beat.eop || (exp_cred != '0));
    assign accept   = i_in_vld && o_in_rdy;

    assign smp_spend = accept;
    // Exponent credit reserved at eop, the push comes two cycles later
    assign exp_spend = accept && i_in_beat.eop;

    assign o_smp_push = accept;
    assign o_smp_beat = i_in_beat;

    // --------------------
    // Credit counters
    // --------------------

    always_ff @(posedge clk)
    begin
        if (rst)
            smp_cred <= SMP_CW'(SAMPLE_DEPTH);
        else
        begin
            case ({smp_spend, i_smp_credit})
                2'b10:   smp_cred <= smp_cred - 1'b1;
                2'b01:   smp_cred <= smp_cred + 1'b1;
                default: smp_cred <= smp_cred;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            exp_cred <= EXP_CW'(EXP_DEPTH);
        else
        begin
            case ({exp_spend, i_exp_credit})
                2'b10:   exp_cred <= exp_cred - 1'b1;
                2'b01:   exp_cred <= exp_cred + 1'b1;
                default: exp_cred <= exp_cred;
            endcase
        end
    end

    // --------------------
    // Peak scan
    // --------------------

    bfp_peak_scan u_scan
    (
        .clk       (clk),
        .rst       (rst),
        .i_vld     (accept),
        .i_beat    (i_in_beat),
        .o_exp_vld (scan_vld),
        .o_exp     (scan_exp)
    );

    // Already covered by the reserved credit
    assign o_exp_push    = scan_vld;
    assign o_exp_rec.exp = scan_exp;

endmodule

// ==== bfp_normalizer.sv ====
/*
 * Consumer side. Pairs the exponent at the head of the exponent buffer
 * with the frame at the head of the sample buffer, shifts each sample
 * left by it, and holds the result in an output register.
 */

module bfp_normalizer
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_exp_vld,
    input  bfp_flow_pkg::exp_rec_t i_exp_rec,
    output logic                   o_exp_pop,
    input  logic                   i_smp_vld,
    input  bfp_sample_pkg::beat_t  i_smp_beat,
    output logic                   o_smp_pop,
    output logic                   o_out_vld,
    output bfp_sample_pkg::beat_t  o_out_beat,
    output bfp_sample_pkg::exp_t   o_out_exp,
    input  logic                   i_out_rdy
);

    // Output register free or being drained this cycle
    logic                  out_free;
    logic                  take;
    bfp_sample_pkg::beat_t shifted;

    // --------------------
    // Pop control
    // --------------------

    assign out_free = !o_out_vld || i_out_rdy;

    // Exponents arrive only after their eop, so the exponent head
    // always belongs to the frame at the sample head
    assign take = i_exp_vld && i_smp_vld && out_free;

    assign o_smp_pop = take;
    // Exponent leaves with the last beat of its frame
    assign o_exp_pop = take && i_smp_beat.eop;

    // --------------------
    // Shift
    // --------------------

    always_comb
    begin
        shifted         = i_smp_beat;
        shifted.data.re = i_smp_beat.data.re <<< i_exp_rec.exp;
        shifted.data.im = i_smp_beat.data.im <<< i_exp_rec.exp;
    end

    // --------------------
    // Output register
    // --------------------

    // Valid holds until the sink takes the beat
    always_ff @(posedge clk)
    begin
        if (rst)
            o_out_vld <= 1'b0;
        else if (take)
            o_out_vld <= 1'b1;
        else if (i_out_rdy)
            o_out_vld <= 1'b0;
    end

    // Payload only changes on a new pop, so it is stable while stalled
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            o_out_beat <= shifted;
            o_out_exp  <= i_exp_rec.exp;
        end
    end

endmodule

// ==== bfp_top.sv ====
/*
 * Block-floating-point normalizer top. Valid/ready in and out;
 * internally the ingress feeds two credit FIFOs drained by the
 * normalizer.
 */

module bfp_top
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_in_vld,
    input  bfp_sample_pkg::beat_t i_in_beat,
    output logic                  o_in_rdy,
    output logic                  o_out_vld,
    output bfp_sample_pkg::beat_t o_out_beat,
    output bfp_sample_pkg::exp_t  o_out_exp,
    input  logic                  i_out_rdy
);

    // A whole frame waits for its exponent, so one frame must fit
    localparam int SAMPLE_DEPTH = bfp_flow_pkg::FRAME_MAX;
    localparam int EXP_DEPTH    = bfp_flow_pkg::EXP_DEPTH;

    // Sample path
    logic                   smp_push;
    bfp_sample_pkg::beat_t  smp_in;
    logic                   smp_vld;
    bfp_sample_pkg::beat_t  smp_head;
    logic                   smp_pop;
    logic                   smp_credit;
    // Exponent path
    logic                   exp_push;
    bfp_flow_pkg::exp_rec_t exp_in;
    logic                   exp_vld;
    bfp_flow_pkg::exp_rec_t exp_head;
    logic                   exp_pop;
    logic                   exp_credit;

    bfp_ingress #(
        .SAMPLE_DEPTH (SAMPLE_DEPTH),
        .EXP_DEPTH    (EXP_DEPTH)
    ) u_ingress (
        .clk          (clk),
        .rst          (rst),
        .i_in_vld     (i_in_vld),
        .i_in_beat    (i_in_beat),
        .o_in_rdy     (o_in_rdy),
        .o_smp_push   (smp_push),
        .o_smp_beat   (smp_in),
        .i_smp_credit (smp_credit),
        .o_exp_push   (exp_push),
        .o_exp_rec    (exp_in),
        .i_exp_credit (exp_credit)
    );

    bfp_credit_fifo #(
        .T     (bfp_sample_pkg::beat_t),
        .DEPTH (SAMPLE_DEPTH)
    ) u_smp_buf (
        .clk      (clk),
        .rst      (rst),
        .i_push   (smp_push),
        .i_data   (smp_in),
        .o_vld    (smp_vld),
        .o_data   (smp_head),
        .i_pop    (smp_pop),
        .o_credit (smp_credit)
    );

    bfp_credit_fifo #(
        .T     (bfp_flow_pkg::exp_rec_t),
        .DEPTH (EXP_DEPTH)
    ) u_exp_buf (
        .clk      (clk),
        .rst      (rst),
        .i_push   (exp_push),
        .i_data   (exp_in),
        .o_vld    (exp_vld),
        .o_data   (exp_head),
        .i_pop    (exp_pop),
        .o_credit (exp_credit)
    );

    bfp_normalizer u_norm (
        .clk        (clk),
        .rst        (rst),
        .i_exp_vld  (exp_vld),
        .i_exp_rec  (exp_head),
        .o_exp_pop  (exp_pop),
        .i_smp_vld  (smp_vld),
        .i_smp_beat (smp_head),
        .o_smp_pop  (smp_pop),
        .o_out_vld  (o_out_vld),
        .o_out_beat (o_out_beat),
        .o_out_exp  (o_out_exp),
        .i_out_rdy  (i_out_rdy)
    );

endmodule

// ==== bfp_top_chk.sv ====
/*
 * Concurrent checks on credit use and output stall. Bound into bfp_top
 * and wired to the ingress, buffer and normalizer instances.
 */

module bfp_top_chk
#(
    parameter int SAMPLE_DEPTH = 64,
    parameter int EXP_DEPTH    = 4
)
(
    input logic                                         clk,
    input logic                                         rst,
    input logic                                         i_smp_push,
    input logic [bfp_flow_pkg::cnt_w(SAMPLE_DEPTH)-1:0] i_smp_cnt,
    input logic                                         i_exp_push,
    input logic [bfp_flow_pkg::cnt_w(EXP_DEPTH)-1:0]    i_exp_cnt,
    input logic [bfp_flow_pkg::cnt_w(SAMPLE_DEPTH)-1:0] i_smp_cred,
    input logic [bfp_flow_pkg::cnt_w(EXP_DEPTH)-1:0]    i_exp_cred,
    input logic                                         i_out_vld,
    input logic                                         i_out_rdy,
    input bfp_sample_pkg::beat_t                        i_out_beat,
    input bfp_sample_pkg::exp_t                         i_out_exp
);

    // Assertion failures so far
    int n_fail = 0;

    // --------------------
    // Credits
    // --------------------

    // Held sample credits keep every push within the buffer
    a_smp_room : assert property (
        @(posedge clk) disable iff (rst) i_smp_push |-> (i_smp_cnt < SAMPLE_DEPTH)
    )
    else
    begin
        $error("sample push into a full sample buffer");
        n_fail++;
    end

    // Reserved exponent credit must still cover the late push
    a_exp_room : assert property (
        @(posedge clk) disable iff (rst) i_exp_push |-> (i_exp_cnt < EXP_DEPTH)
    )
    else
    begin
        $error("exponent push into a full exponent buffer");
        n_fail++;
    end

    // Credit counters never above buffer depth
    a_cred_range : assert property (
        @(posedge clk) disable iff (rst)
        (i_smp_cred <= SAMPLE_DEPTH) && (i_exp_cred <= EXP_DEPTH)
    )
    else
    begin
        $error("credit counter above buffer depth");
        n_fail++;
    end

    // --------------------
    // Output stall
    // --------------------

    a_out_hold : assert property (
        @(posedge clk) disable iff (rst)
        (i_out_vld && !i_out_rdy) |=>
            (i_out_vld && $stable(i_out_beat) && $stable(i_out_exp))
    )
    else
    begin
        $error("output changed while stalled");
        n_fail++;
    end

endmodule

bind bfp_top bfp_top_chk #(
    .SAMPLE_DEPTH (SAMPLE_DEPTH),
    .EXP_DEPTH    (EXP_DEPTH)
) u_chk (
    .clk         (clk),
    .rst         (rst),
    .i_smp_push  (u_ingress.o_smp_push),
    .i_smp_cnt   (u_smp_buf.count),
    .i_exp_push  (u_ingress.o_exp_push),
    .i_exp_cnt   (u_exp_buf.count),
    .i_smp_cred  (u_ingress.smp_cred),
    .i_exp_cred  (u_ingress.exp_cred),
    .i_out_vld   (u_norm.o_out_vld),
    .i_out_rdy   (u_norm.i_out_rdy),
    .i_out_beat  (u_norm.o_out_beat),
    .i_out_exp   (u_norm.o_out_exp)
);

// ==== tb_bfp_top.sv ====
/*
 * Testbench for the block-floating-point normalizer. Frames from a table
 * go in with LCG samples, a reference model predicts every output beat,
 * and a random sink applies back-pressure.
 */

module tb_bfp_top;

    localparam int          W        = bfp_sample_pkg::SAMPLE_W;
    localparam logic [31:0] SEED     = 32'h1e983c4b;
    localparam int          N_FRAMES = 14;
    localparam int          SLACK    = 1000;

    // One row per frame
    typedef struct packed {
        int           len;
        logic [W-1:0] amp;
        logic         minus_one;
        int           rdy_pct;
    } frame_cfg_t;

    // --------------------
    // Frame table
    // --------------------

    localparam frame_cfg_t FRAMES [N_FRAMES] = '{
        '{8,  16'h7fff, 1'b0, 100},   // Full scale
        '{8,  16'h00ff, 1'b0, 100},   // Mid scale
        '{5,  16'h0000, 1'b0, 100},   // All zero, exponent W-1
        '{6,  16'h0000, 1'b1, 100},   // All minus one
        '{1,  16'h0fff, 1'b0, 100},   // Single-beat frames
        '{1,  16'h003f, 1'b0, 100},
        '{3,  16'h01ff, 1'b0, 90},
        '{12, 16'h1fff, 1'b0, 50},
        '{1,  16'h0007, 1'b0, 30},
        '{20, 16'h07ff, 1'b0, 30},
        '{64, 16'h7fff, 1'b0, 100},   // FRAME_MAX frames
        '{64, 16'h03ff, 1'b0, 40},
        '{64, 16'h0001, 1'b0, 25},
        '{2,  16'h3fff, 1'b0, 60}
    };

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  i_in_vld;
    bfp_sample_pkg::beat_t i_in_beat;
    logic                  o_in_rdy;
    logic                  o_out_vld;
    bfp_sample_pkg::beat_t o_out_beat;
    bfp_sample_pkg::exp_t  o_out_exp;
    logic                  i_out_rdy;

    // Expected output, queued before each frame goes in
    bfp_sample_pkg::beat_t want_beat_q [$];
    bfp_sample_pkg::exp_t  want_exp_q [$];
    // Separate LCG streams for data and sink ready
    logic [31:0]           data_state = SEED;
    logic [31:0]           rdy_state  = SEED;
    int                    rdy_pct    = 100;
    logic                  saw_rdy_low = 1'b0;

    bfp_top UUT
    (
        .clk        (clk),
        .rst        (rst),
        .i_in_vld   (i_in_vld),
        .i_in_beat  (i_in_beat),
        .o_in_rdy   (o_in_rdy),
        .o_out_vld  (o_out_vld),
        .o_out_beat (o_out_beat),
        .o_out_exp  (o_out_exp),
        .i_out_rdy  (i_out_rdy)
    );

    always #2 clk = ~clk;

    // --------------------
    // Reference model
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Masked LCG value, sign flipped on a further LCG bit
    function automatic logic signed [W-1:0] next_part(input frame_cfg_t cfg);
        logic signed [W-1:0] v;
        if (cfg.minus_one)
            return '1;
        data_state = lcg_next(data_state);
        v = data_state[31:16] & cfg.amp;
        if (data_state[15])
            v = -v;
        return v;
    endfunction

    // Negative values are bit-inverted, not negated
    function automatic logic [W-1:0] ones_mag(input logic signed [W-1:0] x);
        return x[W-1] ? ~x : x;
    endfunction

    // Leading zeros below the sign bit
    function automatic bfp_sample_pkg::exp_t exp_of_mask(input logic [W-1:0] m);
        int pos;
        pos = W - 2;
        while (pos >= 0 && !m[pos])
            pos--;
        return bfp_sample_pkg::exp_t'(W - 2 - pos);
    endfunction

    function automatic logic signed [W-1:0] shift_left(input logic signed [W-1:0] x,
                                                        input bfp_sample_pkg::exp_t e);
        logic [W-1:0] r;
        r = x;
        r = r << e;
        return r;
    endfunction

    function automatic int total_beats();
        int n;
        n = 0;
        foreach (FRAMES[f])
            n += FRAMES[f].len;
        return n;
    endfunction

    // --------------------
    // Checks
    // --------------------

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        end_with_failure();
    endtask

    task automatic check_beat(input string name, input bfp_sample_pkg::beat_t want,
                              input bfp_sample_pkg::beat_t got);
        if (got !== want)
        begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, want, got);
            end_with_failure();
        end
    endtask

    task automatic check_exp(input string name, input bfp_sample_pkg::exp_t want,
                             input bfp_sample_pkg::exp_t got);
        if (got !== want)
        begin
            $display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, want, got);
            end_with_failure();
        end
    endtask

    // --------------------
    // Frame driver
    // --------------------

    // Build, predict, then send one frame
    task automatic run_frame(input frame_cfg_t cfg);
        bfp_sample_pkg::beat_t frame [$];
        bfp_sample_pkg::beat_t b;
        logic [W-1:0]          mask;
        bfp_sample_pkg::exp_t  e;
        mask = '0;
        for (int k = 0; k < cfg.len; k++)
        begin
            b         = '0;
            b.data.re = next_part(cfg);
            b.data.im = next_part(cfg);
            b.sop     = (k == 0);
            b.eop     = (k == cfg.len - 1);
            mask      = mask | ones_mag(b.data.re) | ones_mag(b.data.im);
            frame.push_back(b);
        end
        e = exp_of_mask(mask);
        foreach (frame[k])
        begin
            b         = frame[k];
            b.data.re = shift_left(frame[k].data.re, e);
            b.data.im = shift_left(frame[k].data.im, e);
            want_beat_q.push_back(b);
            want_exp_q.push_back(e);
        end
        // Hold each beat until the edge where ready was seen high
        foreach (frame[k])
        begin
            i_in_vld  <= 1'b1;
            i_in_beat <= frame[k];
            @(posedge clk);
            while (!o_in_rdy)
            begin
                saw_rdy_low = 1'b1;
                @(posedge clk);
            end
        end
    endtask

    initial
    begin : main
        rst       = 1'b1;
        i_in_vld  = 1'b0;
        i_in_beat = '0;
        i_out_rdy = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (o_in_rdy !== 1'b1 || o_out_vld !== 1'b0)
            abort_run("ready/valid not in their reset state after reset");
        for (int f = 0; f < N_FRAMES; f++)
        begin
            rdy_pct = FRAMES[f].rdy_pct;
            run_frame(FRAMES[f]);
        end
        i_in_vld <= 1'b0;
        while (want_beat_q.size() != 0)
            @(posedge clk);
        // Idle window to catch stray output beats
        repeat (10) @(posedge clk);
        if (!saw_rdy_low)
        begin
            $display("ERROR: input ready never fell while the output was stalled");
            end_with_failure();
        end
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    // Sink with random ready, compares each taken beat
    initial
    begin : sink
        forever
        begin
            @(posedge clk);
            if (UUT.u_chk.n_fail != 0)
                abort_run("a bound assertion in bfp_top_chk failed");
            if (rst === 1'b0 && o_out_vld === 1'b1 && i_out_rdy === 1'b1)
            begin
                if (want_beat_q.size() == 0)
                    abort_run("output beat arrived with nothing expected");
                check_beat("o_out_beat", want_beat_q.pop_front(), o_out_beat);
                check_exp("o_out_exp", want_exp_q.pop_front(), o_out_exp);
            end
            rdy_state = lcg_next(rdy_state);
            i_out_rdy <= (int'(rdy_state[31:16]) % 100) < rdy_pct;
        end
    end

    initial
    begin : watchdog
        int limit;
        int cycles;
        limit  = total_beats() * 4 + SLACK;
        cycles = 0;
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        abort_run($sformatf("timeout after %0d cycles with output still pending", limit));
    end

endmodule

// ==== vlog.f ====
bfp_sample_pkg.sv
bfp_flow_pkg.sv
bfp_peak_scan.sv
bfp_credit_fifo.sv
bfp_ingress.sv
bfp_normalizer.sv
bfp_top.sv
bfp_top_chk.sv
tb_bfp_top.sv

// ==== Bender.yml ====
package:
  name: bfp_normalizer

sources:
  - bfp_sample_pkg.sv
  - bfp_flow_pkg.sv
  - bfp_peak_scan.sv
  - bfp_credit_fifo.sv
  - bfp_ingress.sv
  - bfp_normalizer.sv
  - bfp_top.sv
  - target: test
    files:
      - bfp_top_chk.sv
      - tb_bfp_top.sv
